/* sim/exSubsystem_golden.txt */
# op pc imm nick rs1Ready rs1Word rs2Ready rs2Word expData expTaken expJumpPc (all hex)
# op is the opT code, an operand word is a value when its ready flag is 1 and a tag otherwise
00 00000100 12345000 0 1 00000000 1 00000000 12345000 0 00000104
01 00000104 00002000 1 1 00000000 1 00000000 00002104 0 00000108
0a 00000108 fffffff0 2 1 00000005 1 00000000 fffffff5 0 0000010c
0b 0000010c 00000003 3 1 fffffffe 1 00000000 00000001 0 00000110
0c 00000110 00000003 4 1 fffffffe 1 00000000 00000000 0 00000114
0d 00000114 0000ff00 5 1 12345678 1 00000000 1234a978 0 00000118
0e 00000118 0000000f 6 1 a0a0a0a0 1 00000000 a0a0a0af 0 0000011c
0f 0000011c 00000ff0 7 1 12345678 1 00000000 00000670 0 00000120
10 00000120 00000024 8 1 0000000f 1 00000000 000000f0 0 00000124
11 00000124 00000004 9 1 f0000000 1 00000000 0f000000 0 00000128
12 00000128 00000404 a 1 f0000000 1 00000000 ff000000 0 0000012c
13 0000012c 00000000 b 1 7fffffff 1 00000001 80000000 0 00000130
14 00000130 00000000 c 1 00000003 1 00000005 fffffffe 0 00000134
15 00000134 00000000 d 1 00000001 1 0000003f 80000000 0 00000138
16 00000138 00000000 e 1 80000000 1 00000001 00000001 0 0000013c
17 0000013c 00000000 f 1 80000000 1 00000001 00000000 0 00000140
18 00000140 00000000 0 1 ff00ff00 1 0ff00ff0 f0f0f0f0 0 00000144
19 00000144 00000000 1 1 80000000 1 0000001f 00000001 0 00000148
1a 00000148 00000000 2 1 80000000 1 0000001f ffffffff 0 0000014c
1b 0000014c 00000000 3 1 00ff0000 1 000000ff 00ff00ff 0 00000150
1c 00000150 00000000 4 1 ff00ff00 1 0ff00ff0 0f000f00 0 00000154
04 00000200 00000010 5 1 00000005 1 00000005 00000000 1 00000210
05 00000204 00000010 6 1 00000005 1 00000005 00000000 0 00000208
06 00000208 fffffff8 7 1 ffffffff 1 00000001 00000000 1 00000200
07 0000020c 00000020 8 1 ffffffff 1 00000001 00000000 0 00000210
08 00000210 00000040 9 1 ffffffff 1 00000001 00000000 0 00000214
09 00000214 00000040 a 1 ffffffff 1 00000001 00000000 1 00000254
04 00000218 00000010 b 1 00000005 1 00000006 00000000 0 0000021c
05 0000021c fffffffc c 1 00000005 1 00000006 00000000 1 00000218
06 00000220 00000008 d 1 00000001 1 ffffffff 00000000 0 00000224
07 00000224 00000008 e 1 00000001 1 ffffffff 00000000 1 0000022c
08 00000228 00000008 f 1 00000001 1 ffffffff 00000000 1 00000230
09 0000022c 00000008 0 1 00000001 1 ffffffff 00000000 0 00000230
02 00000230 00000100 1 1 00000000 1 00000000 00000234 1 00000330
03 00000234 00000005 2 1 00001000 1 00000000 00000238 1 00001004
0a 00000300 00000001 3 1 00000010 1 00000000 00000011 0 00000304
13 00000304 00000000 4 0 00000003 0 00000003 00000022 0 00000308
14 00000308 00000000 5 0 00000004 1 00000002 00000020 0 0000030c
10 0000030c 00000003 6 0 00000005 1 00000000 00000100 0 00000310
18 00000310 00000000 7 0 00000006 0 00000003 00000111 0 00000314
0a 00000314 00000001 8 0 00000007 1 00000000 00000112 0 00000318
0e 00000318 0000f000 9 0 00000007 1 00000000 0000f111 0 0000031c
11 0000031c 00000004 a 0 00000007 1 00000000 00000011 0 00000320
17 00000320 00000000 b 0 00000007 1 00000200 00000001 0 00000324
03 00000324 00000003 c 0 00000008 1 00000000 00000328 1 00000114
04 00000328 00000040 d 0 0000000a 0 00000003 00000000 1 00000368
1c 0000032c 00000000 e 0 00000009 0 0000000b 00000001 0 00000330

/* src.f */
rtl/rvIsaPkg.sv
rtl/cdbPkg.sv
rtl/rsStation.sv
rtl/execUnit.sv
rtl/exSubsystem.sv
sim/exSubsystem_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the execute slice testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -j 0 --top-module exSubsystem_tb -f src.f
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/VexSubsystem_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Simulation completed successfully" sim.log; then
    echo "PASS"
    exit 0
fi
echo "FAIL"
exit 1

/* sim/exSubsystem_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module exSubsystem_tb;

    localparam int rsDepth  = 4;
    localparam int numNicks = 1 << rvIsaPkg::nickWidth;

    logic          clk;
    logic          rst;
    logic          rdy;
    logic          issueEn;
    cdbPkg::issueT issue;
    logic          issueAccept;
    cdbPkg::cdbT   cdb;

    cdbPkg::issueT  recIssue[$];        // Records in file order
    cdbPkg::cdbT    recExpect[$];
    cdbPkg::cdbT    expectByNick[numNicks];
    logic           pending[numNicks];
    logic           issuedOnce[numNicks];
    logic           produced[numNicks]; // Result seen for the latest holder of the tag
    rvIsaPkg::dataT producedData[numNicks];

    int          seed;
    int          cycles = 0;
    int          timeoutLimit = 200;
    int          nextRec;
    int          issuedCount;
    int          completedCount;
    int          stallLeft;
    int          stallCycles;
    int          backPressureCycles;
    logic        lastRdy;
    cdbPkg::cdbT lastCdb;

    exSubsystem #(
        .rsDepth(rsDepth)
    ) exSubsystem_inst (
        .clk        (clk),
        .rst        (rst),
        .rdy        (rdy),
        .issueEn    (issueEn),
        .issue      (issue),
        .issueAccept(issueAccept),
        .cdb        (cdb)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    task automatic failRun(input string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic flagMismatch(input string msg);
        failRun($sformatf("CHECK FAILED at %0d ns: %s", $time, msg));
    endtask

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > timeoutLimit) begin
            failRun($sformatf("Timeout after %0d cycles, only %0d of %0d results arrived",
                cycles, completedCount, recIssue.size()));
        end
    end

    task automatic loadGolden();
        int             fd;
        int             n;
        string          line;
        cdbPkg::issueT  rec;
        cdbPkg::cdbT    want;
        logic [4:0]     op;
        logic [3:0]     nick;
        logic           r1Rdy;
        logic           r2Rdy;
        logic           taken;
        rvIsaPkg::dataT pc;
        rvIsaPkg::dataT imm;
        rvIsaPkg::dataT r1Word;
        rvIsaPkg::dataT r2Word;
        rvIsaPkg::dataT data;
        rvIsaPkg::dataT jumpPc;
        fd = $fopen("sim/exSubsystem_golden.txt", "r");
        if (fd == 0) begin
            failRun("Could not open sim/exSubsystem_golden.txt");
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (n > 0 && line.len() > 1 && line.getc(0) != 8'h23) begin // Skip comment lines
                n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h", op, pc, imm, nick,
                    r1Rdy, r1Word, r2Rdy, r2Word, data, taken, jumpPc);
                if (n != 11) begin
                    failRun($sformatf("Golden file line is malformed: %s", line));
                end
                rec.op             = rvIsaPkg::opT'(op);
                rec.pc             = pc;
                rec.imm            = imm;
                rec.rdNick         = nick;
                rec.rs1.ready      = r1Rdy;
                rec.rs1.word.value = r1Word; // Tag sits in the low bits when not ready
                rec.rs2.ready      = r2Rdy;
                rec.rs2.word.value = r2Word;
                want.valid  = 1'b1;
                want.nick   = nick;
                want.data   = data;
                want.taken  = taken;
                want.jumpPc = jumpPc;
                recIssue.push_back(rec);
                recExpect.push_back(want);
            end
        end
        $fclose(fd);
    endtask

    task automatic checkCdb(input cdbPkg::cdbT got);
        cdbPkg::cdbT want;
        want = expectByNick[got.nick];
        if (!issuedOnce[got.nick]) begin
            flagMismatch($sformatf("result for tag %0d that was never issued", got.nick));
        end else if (!pending[got.nick]) begin
            flagMismatch($sformatf("tag %0d completed twice", got.nick));
        end else if (got.data !== want.data || got.taken !== want.taken ||
                     got.jumpPc !== want.jumpPc) begin
            flagMismatch($sformatf("tag %0d gave data %h taken %0b target %h, expected %h %0b %h",
                got.nick, got.data, got.taken, got.jumpPc, want.data, want.taken, want.jumpPc));
        end
    endtask

    // Slots in use are bounded by what is issued and not yet seen on the bus
    task automatic checkAccept(input logic got);
        int inStation;
        inStation = issuedCount - completedCount - int'(cdb.valid);
        if (!rdy && got) begin
            flagMismatch("issueAccept high while rdy is low");
        end else if (rdy && inStation < rsDepth && !got) begin
            flagMismatch($sformatf("issueAccept low with at most %0d of %0d slots in use",
                inStation, rsDepth));
        end
    endtask

    // Issue stage picks up results that already went by
    function automatic cdbPkg::operandT resolveOperand(input cdbPkg::operandT opnd);
        cdbPkg::operandT res;
        res = opnd;
        if (!opnd.ready && produced[opnd.word.tag.nick]) begin
            res.ready      = 1'b1;
            res.word.value = producedData[opnd.word.tag.nick];
        end
        return res;
    endfunction

    task automatic presentRecord();
        cdbPkg::issueT rec;
        if (nextRec < recIssue.size() && !pending[recIssue[nextRec].rdNick]) begin
            rec     = recIssue[nextRec];
            rec.rs1 = resolveOperand(rec.rs1);
            rec.rs2 = resolveOperand(rec.rs2);
            issueEn <= 1'b1;
            issue   <= rec;
        end else begin
            issueEn <= 1'b0; // Done, or tag still in flight
        end
    endtask

    task automatic driveStall();
        int r;
        if (stallLeft > 0) begin
            stallLeft = stallLeft - 1;
            rdy <= 1'b0;
        end else begin
            r = $random(seed);
            if ((r & 7) == 0) begin
                stallLeft = (r >> 4) & 3; // One to four cycles
                rdy <= 1'b0;
            end else begin
                rdy <= 1'b1;
            end
        end
    endtask

    task automatic serviceEdge();
        cdbPkg::issueT rec;
        checkAccept(issueAccept);
        if (!lastRdy && cdb !== lastCdb) begin
            flagMismatch("CDB word changed while rdy was low");
        end
        if (rdy && cdb.valid) begin
            checkCdb(cdb);
            pending[cdb.nick]      = 1'b0;
            produced[cdb.nick]     = 1'b1;
            producedData[cdb.nick] = cdb.data;
            completedCount         = completedCount + 1;
        end
        if (issueEn && issueAccept) begin
            rec = recIssue[nextRec];
            expectByNick[rec.rdNick] = recExpect[nextRec];
            pending[rec.rdNick]      = 1'b1;
            issuedOnce[rec.rdNick]   = 1'b1;
            produced[rec.rdNick]     = 1'b0;
            issuedCount              = issuedCount + 1;
            nextRec                  = nextRec + 1;
        end
        if (!rdy) begin
            stallCycles = stallCycles + 1;
        end else if (!issueAccept) begin
            backPressureCycles = backPressureCycles + 1;
        end
        lastRdy = rdy;
        lastCdb = cdb;
        presentRecord();
        driveStall();
    endtask

    initial begin
        rst     <= 1'b1;
        rdy     <= 1'b0;
        issueEn <= 1'b0;
        issue   <= '0;
        seed           = 32'h4392_07f8;
        nextRec        = 0;
        issuedCount    = 0;
        completedCount = 0;
        stallLeft      = 0;
        stallCycles    = 0;
        backPressureCycles = 0;
        for (int i = 0; i < numNicks; i++) begin
            pending[i]    = 1'b0;
            issuedOnce[i] = 1'b0;
            produced[i]   = 1'b0;
        end
        loadGolden();
        timeoutLimit = 40 * recIssue.size() + 200;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        rdy <= 1'b1;
        repeat (4) begin
            @(posedge clk);
            if (cdb.valid) begin
                flagMismatch("CDB valid before any record was issued");
            end
            checkAccept(issueAccept);
        end
        lastRdy = 1'b1;
        lastCdb = cdb;
        presentRecord();
        while (completedCount < recIssue.size()) begin
            @(posedge clk);
            serviceEdge();
        end
        if (stallCycles > 0 && backPressureCycles > 0) begin
            $display("Simulation completed successfully");
            $finish;
        end else begin
            failRun("Stalls or a full station never occurred during the run");
        end
    end

endmodule

`default_nettype wire

/* rtl/exSubsystem.sv */
`timescale 1ns/100ps
`default_nettype none

module exSubsystem #(
    parameter int rsDepth = 4
) (
    input  logic          clk,
    input  logic          rst,
    input  logic          rdy,
    input  logic          issueEn,
    input  cdbPkg::issueT issue,
    output logic          issueAccept,
    output cdbPkg::cdbT   cdb
);

    logic             dispatchEn;
    cdbPkg::dispatchT dispatch;

    // Station wakes up from the same CDB that leaves the slice
    rsStation #(
        .rsDepth(rsDepth)
    ) rsStation_inst (
        .clk        (clk),
        .rst        (rst),
        .rdy        (rdy),
        .issueEn    (issueEn),
        .issue      (issue),
        .issueAccept(issueAccept),
        .cdb        (cdb),
        .dispatchEn (dispatchEn),
        .dispatch   (dispatch)
    );

    execUnit execUnit_inst (
        .clk       (clk),
        .rst       (rst),
        .rdy       (rdy),
        .dispatchEn(dispatchEn),
        .dispatch  (dispatch),
        .cdb       (cdb)
    );

endmodule

`default_nettype wire

/* rtl/execUnit.sv */
`timescale 1ns/100ps
`default_nettype none

module execUnit (
    input  logic             clk,
    input  logic             rst,
    input  logic             rdy,
    input  logic             dispatchEn,
    input  cdbPkg::dispatchT dispatch,
    output cdbPkg::cdbT      cdb
);

    localparam int zeroPad = rvIsaPkg::dataWidth - 1;

    rvIsaPkg::dataT data;
    rvIsaPkg::dataT jumpPc;
    logic           taken;
    logic           brCond;
    rvIsaPkg::dataT seqPc;
    rvIsaPkg::dataT targetPc;

    assign seqPc    = dispatch.pc + 32'd4;
    assign targetPc = dispatch.pc + dispatch.imm;

    // Branch compares
    always_comb begin
        case (dispatch.op)
            rvIsaPkg::BEQ:  brCond = dispatch.rs1 == dispatch.rs2;
            rvIsaPkg::BNE:  brCond = dispatch.rs1 != dispatch.rs2;
            rvIsaPkg::BLT:  brCond = $signed(dispatch.rs1) < $signed(dispatch.rs2);
            rvIsaPkg::BGE:  brCond = $signed(dispatch.rs1) >= $signed(dispatch.rs2);
            rvIsaPkg::BLTU: brCond = dispatch.rs1 < dispatch.rs2;
            rvIsaPkg::BGEU: brCond = dispatch.rs1 >= dispatch.rs2;
            default:        brCond = 1'b0;
        endcase
    end

    always_comb begin
        data   = '0;
        taken  = rvIsaPkg::notJump;
        jumpPc = seqPc; // Fall-through unless a jump or taken branch
        case (dispatch.op)
            rvIsaPkg::LUI:   data = dispatch.imm;
            rvIsaPkg::AUIPC: data = targetPc;
            rvIsaPkg::JAL: begin
                data   = seqPc;
                taken  = rvIsaPkg::jump;
                jumpPc = targetPc;
            end
            rvIsaPkg::JALR: begin
                data   = seqPc;
                taken  = rvIsaPkg::jump;
                jumpPc = (dispatch.rs1 + dispatch.imm) & ~32'd1;
            end
            rvIsaPkg::BEQ, rvIsaPkg::BNE, rvIsaPkg::BLT,
            rvIsaPkg::BGE, rvIsaPkg::BLTU, rvIsaPkg::BGEU: begin
                if (brCond) begin
                    taken  = rvIsaPkg::jump;
                    jumpPc = targetPc;
                end
            end
            rvIsaPkg::ADDI:  data = dispatch.rs1 + dispatch.imm;
            rvIsaPkg::SLTI:
                data = {{zeroPad{1'b0}}, $signed(dispatch.rs1) < $signed(dispatch.imm)};
            rvIsaPkg::SLTIU: data = {{zeroPad{1'b0}}, dispatch.rs1 < dispatch.imm};
            rvIsaPkg::XORI:  data = dispatch.rs1 ^ dispatch.imm;
            rvIsaPkg::ORI:   data = dispatch.rs1 | dispatch.imm;
            rvIsaPkg::ANDI:  data = dispatch.rs1 & dispatch.imm;
            rvIsaPkg::SLLI:  data = dispatch.rs1 << dispatch.imm[4:0];
            rvIsaPkg::SRLI:  data = dispatch.rs1 >> dispatch.imm[4:0];
            rvIsaPkg::SRAI:  data = $signed(dispatch.rs1) >>> dispatch.imm[4:0];
            rvIsaPkg::ADD:   data = dispatch.rs1 + dispatch.rs2;
            rvIsaPkg::SUB:   data = dispatch.rs1 - dispatch.rs2;
            rvIsaPkg::SLL:   data = dispatch.rs1 << dispatch.rs2[4:0];
            rvIsaPkg::SLT:
                data = {{zeroPad{1'b0}}, $signed(dispatch.rs1) < $signed(dispatch.rs2)};
            rvIsaPkg::SLTU:  data = {{zeroPad{1'b0}}, dispatch.rs1 < dispatch.rs2};
            rvIsaPkg::XOR:   data = dispatch.rs1 ^ dispatch.rs2;
            rvIsaPkg::SRL:   data = dispatch.rs1 >> dispatch.rs2[4:0];
            rvIsaPkg::SRA:   data = $signed(dispatch.rs1) >>> dispatch.rs2[4:0];
            rvIsaPkg::OR:    data = dispatch.rs1 | dispatch.rs2;
            rvIsaPkg::AND:   data = dispatch.rs1 & dispatch.rs2;
            default:         data = '0;
        endcase
    end

    // CDB register, held while stalled
    always_ff @(posedge clk) begin
        if (rst) begin
            cdb.valid <= 1'b0;
        end else if (rdy) begin
            cdb.valid <= dispatchEn;
            if (dispatchEn) begin
                cdb.nick   <= dispatch.rdNick;
                cdb.data   <= data;
                cdb.taken  <= taken;
                cdb.jumpPc <= jumpPc;
            end
        end
    end

    // Station never hands over a garbage opcode
    assert property (@(posedge clk) disable iff (rst)
        dispatchEn |-> !$isunknown(dispatch.op) && dispatch.op <= rvIsaPkg::AND);

endmodule

`default_nettype wire

/* rtl/rsStation.sv */
`timescale 1ns/100ps
`default_nettype none

module rsStation #(
    parameter int rsDepth = 4
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             rdy,
    input  logic             issueEn,
    input  cdbPkg::issueT    issue,
    output logic             issueAccept,
    input  cdbPkg::cdbT      cdb,
    output logic             dispatchEn,
    output cdbPkg::dispatchT dispatch
);

    localparam int idxWidth = $clog2(rsDepth);

    cdbPkg::issueT        slot [rsDepth];
    logic [rsDepth-1:0]   slotValid;
    cdbPkg::issueT        incoming;
    logic [idxWidth-1:0]  dispIdx;
    logic [idxWidth-1:0]  freeIdx;
    logic                 dispFound;
    logic                 full;
    logic                 issueWrite;

    // A tag match against the broadcast replaces the tag with the value
    function automatic cdbPkg::operandT capture(cdbPkg::operandT opnd, cdbPkg::cdbT bus);
        cdbPkg::operandT res;
        res = opnd;
        if (!opnd.ready && bus.valid && opnd.word.tag.nick == bus.nick) begin
            res.ready      = 1'b1;
            res.word.value = bus.data;
        end
        return res;
    endfunction

    // Bypass for a producer broadcasting in the accept cycle
    always_comb begin
        incoming     = issue;
        incoming.rs1 = capture(issue.rs1, cdb);
        incoming.rs2 = capture(issue.rs2, cdb);
    end

    // Lowest index wins for both searches
    always_comb begin
        dispFound = 1'b0;
        dispIdx   = '0;
        freeIdx   = '0;
        for (int i = rsDepth - 1; i >= 0; i--) begin
            if (slotValid[i] && slot[i].rs1.ready && slot[i].rs2.ready) begin
                dispFound = 1'b1;
                dispIdx   = idxWidth'(i);
            end
            if (!slotValid[i]) begin
                freeIdx = idxWidth'(i);
            end
        end
    end

    assign full        = &slotValid;
    assign issueAccept = rdy && !full;
    assign issueWrite  = issueEn && issueAccept;

    always_ff @(posedge clk) begin
        if (rst) begin
            slotValid  <= '0;
            dispatchEn <= 1'b0;
        end else if (rdy) begin
            dispatchEn <= dispFound;
            if (dispFound) begin
                slotValid[dispIdx] <= 1'b0;
            end
            if (issueWrite) begin
                slotValid[freeIdx] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rdy) begin
            for (int i = 0; i < rsDepth; i++) begin
                slot[i].rs1 <= capture(slot[i].rs1, cdb);
                slot[i].rs2 <= capture(slot[i].rs2, cdb);
            end
            if (issueWrite) begin
                slot[freeIdx] <= incoming; // Lowest free slot takes the record
            end
            if (dispFound) begin
                dispatch.op     <= slot[dispIdx].op;
                dispatch.pc     <= slot[dispIdx].pc;
                dispatch.imm    <= slot[dispIdx].imm;
                dispatch.rdNick <= slot[dispIdx].rdNick;
                dispatch.rs1    <= slot[dispIdx].rs1.word.value;
                dispatch.rs2    <= slot[dispIdx].rs2.word.value;
            end
        end
    end

    // Each write adds an entry and each dispatch removes one
    assert property (@(posedge clk) disable iff (rst)
        rdy |=> $countones(slotValid) ==
            $past($countones(slotValid)) + int'($past(issueWrite)) - int'($past(dispFound)));

    // Entries still waiting on an operand never leave the station
    for (genvar g = 0; g < rsDepth; g++) begin : holdCheck
        assert property (@(posedge clk) disable iff (rst)
            slotValid[g] && !(slot[g].rs1.ready && slot[g].rs2.ready) |=> slotValid[g]);
    end

endmodule

`default_nettype wire

/* rtl/cdbPkg.sv */
`default_nettype none

package cdbPkg;

    localparam int padWidth = rvIsaPkg::dataWidth - rvIsaPkg::nickWidth;

    // Source word is a value once ready, otherwise the producer's tag
    typedef union packed {
        rvIsaPkg::dataT value;
        struct packed {
            logic [padWidth-1:0] pad;
            rvIsaPkg::nickT      nick;
        } tag;
    } operandU;

    typedef struct packed {
        logic    ready; // Word holds a value
        operandU word;
    } operandT;

    // Record from the issue stage
    typedef struct packed {
        rvIsaPkg::opT   op;
        rvIsaPkg::dataT pc;
        rvIsaPkg::dataT imm;
        rvIsaPkg::nickT rdNick;
        operandT        rs1;
        operandT        rs2;
    } issueT;

    // Station to execute unit, operands resolved
    typedef struct packed {
        rvIsaPkg::opT   op;
        rvIsaPkg::dataT pc;
        rvIsaPkg::dataT imm;
        rvIsaPkg::nickT rdNick;
        rvIsaPkg::dataT rs1;
        rvIsaPkg::dataT rs2;
    } dispatchT;

    typedef struct packed {
        logic           valid;
        rvIsaPkg::nickT nick;
        rvIsaPkg::dataT data;
        logic           taken;
        rvIsaPkg::dataT jumpPc;
    } cdbT;

endpackage

`default_nettype wire

/* rtl/rvIsaPkg.sv */
`default_nettype none

package rvIsaPkg;

    localparam int dataWidth = 32; // Data and address width
    localparam int nickWidth = 4;  // Rename tag width, 16 tags in flight

    typedef logic [dataWidth-1:0] dataT;
    typedef logic [nickWidth-1:0] nickT;

    // Integer subset, order matters for the range check in execUnit
    typedef enum logic [4:0] {
        LUI,
        AUIPC,
        JAL,
        JALR,
        BEQ,
        BNE,
        BLT,
        BGE,
        BLTU,
        BGEU,
        ADDI,
        SLTI,
        SLTIU,
        XORI,
        ORI,
        ANDI,
        SLLI,
        SRLI,
        SRAI,
        ADD,
        SUB,
        SLL,
        SLT,
        SLTU,
        XOR,
        SRL,
        SRA,
        OR,
        AND
    } opT;

    // Taken flag values
    localparam logic jump    = 1'b1;
    localparam logic notJump = 1'b0;

endpackage

`default_nettype wire
